// File: verilog/mmu_pkg.sv
package mmu_pkg;

   typedef logic [15:0] word_t;           // bus word
   typedef logic [21:0] paddr_t;          // physical address
   typedef logic [3:0]  rf_idx_t;         // {kernel, page[2:0]}

   typedef enum logic [1:0]
   {
      CMD_TRANS_RD = 2'd0,                // read translation
      CMD_TRANS_WR = 2'd1,                // write translation
      CMD_REG_RD   = 2'd2,                // register read
      CMD_REG_WR   = 2'd3                 // register write
   } mmu_cmd_e;

   typedef enum logic [2:0]
   {
      ST_IDLE   = 3'd0,
      ST_DECODE = 3'd1,
      ST_LOOKUP = 3'd2,
      ST_CHECK  = 3'd3,
      ST_ACK    = 3'd4
   } ctrl_state_e;

   typedef struct packed
   {
      paddr_t pa;                         // relocated address
      logic   nr;                         // non-resident
      logic   le;                         // page length error
      logic   ro;                         // write to read-only page
   } reloc_res_t;

   localparam int      RF_SIZE     = 16;           // PAR/PDR pairs, both sets
   localparam [12:0]   SR0_ADDR    = 13'o17572;
   localparam [12:0]   SR3_ADDR    = 13'o12516;
   localparam [6:0]    KSET_ADDR   = 7'o123;       // address bits 12..6
   localparam [6:0]    USET_ADDR   = 7'o176;
   localparam word_t   PDR_RD_MASK = 16'o077516;   // readable PDR bits
   localparam int      PDR_W_BIT   = 6;            // dirty page
   localparam int      PDR_ED_BIT  = 3;            // expansion direction
   localparam int      PDR_ACC_LSB = 1;
   localparam int      PDR_ACC_MSB = 2;
   localparam int      PDR_PLF_LSB = 8;
   localparam int      PDR_PLF_MSB = 14;
   localparam int      SR3_AS_BIT  = 4;            // 22-bit mapping enable

endpackage

// File: verilog/mmu_if.sv
`timescale 1ns/1ps

interface mmu_rf_if import mmu_pkg::*; ();

   rf_idx_t idx;                          // {kernel, page}
   logic    sel_par;                      // 1 selects PAR, 0 selects PDR
   logic    we_lo;                        // low byte write
   logic    we_hi;                        // high byte write
   word_t   wdata;
   logic    set_w;                        // dirty bit set pulse
   word_t   par;
   word_t   pdr;                          // already masked for reading

   modport ctrl (output idx, sel_par, we_lo, we_hi, wdata, set_w,
                 input  par, pdr);
   modport rf   (input  idx, sel_par, we_lo, we_hi, wdata, set_w,
                 output par, pdr);

endinterface

interface mmu_sr_if import mmu_pkg::*; ();

   logic       wr_sr0;
   logic       wr_sr3;
   word_t      wdata;
   logic       rec_abort;                 // record flags, freeze after
   logic       rec_ok;                    // record page and mode only
   logic [2:0] page;
   logic       user;
   logic [2:0] flags;                     // {nr, le, ro}
   word_t      sr0;
   word_t      sr3;
   logic       mmu_en;
   logic       as_en;
   logic       frozen;

   modport ctrl (output wr_sr0, wr_sr3, wdata, rec_abort, rec_ok, page, user, flags,
                 input  sr0, sr3, mmu_en, as_en, frozen);
   modport sr   (input  wr_sr0, wr_sr3, wdata, rec_abort, rec_ok, page, user, flags,
                 output sr0, sr3, mmu_en, as_en, frozen);

endinterface

// File: verilog/mmu_ctrl.sv
`timescale 1ns/1ps

module mmu_ctrl import mmu_pkg::*;
(
   input  logic       clk,
   input  logic       sr_rst,
   input  logic       req,
   output logic       ack,
   input  mmu_cmd_e   cmd,
   input  logic       user,
   input  word_t      addr,
   input  word_t      wdata,
   output word_t      rdata,
   output paddr_t     pa,
   output logic       abort,
   mmu_rf_if.ctrl     rf,
   mmu_sr_if.ctrl     sr,
   output logic       reloc_start,
   output word_t      reloc_va,
   output word_t      reloc_par,
   output word_t      reloc_pdr,
   output logic       reloc_wr,
   output logic       reloc_as,
   input  reloc_res_t reloc_res
);

   ctrl_state_e state, state_nxt;
   logic        sr0_hit, sr3_hit, kset_hit, uset_hit, set_hit;
   logic        is_trans, is_reg_wr, mapped, fault, in_check, do_wr;
   word_t       rd_mux;

   assign sr0_hit   = (addr[12:1] == SR0_ADDR[12:1]);
   assign sr3_hit   = (addr[12:1] == SR3_ADDR[12:1]);
   assign kset_hit  = (addr[12:6] == KSET_ADDR) & ~addr[4];
   assign uset_hit  = (addr[12:6] == USET_ADDR) & ~addr[4];
   assign set_hit   = kset_hit | uset_hit;

   assign is_trans  = (cmd == CMD_TRANS_RD) | (cmd == CMD_TRANS_WR);
   assign is_reg_wr = (cmd == CMD_REG_WR);
   assign mapped    = is_trans & sr.mmu_en;
   assign fault     = reloc_res.nr | reloc_res.le | reloc_res.ro;
   assign in_check  = (state == ST_CHECK);
   assign do_wr     = (state == ST_DECODE) & is_reg_wr;    // register write slot

   always_ff @(posedge clk)
   begin
      if (sr_rst)
         state <= ST_IDLE;
      else
         state <= state_nxt;
   end

   always_comb
   begin
      state_nxt = state;
      case (state)
         ST_IDLE:   if (req) state_nxt = ST_DECODE;
         ST_DECODE: state_nxt = ST_LOOKUP;
         ST_LOOKUP: state_nxt = ST_CHECK;
         ST_CHECK:  state_nxt = ST_ACK;
         ST_ACK:    if (!req) state_nxt = ST_IDLE;     // held while req stays high
         default:   state_nxt = ST_IDLE;
      endcase
   end

   assign ack = (state == ST_ACK);

   // page select comes from the VA on translations, from the address otherwise
   assign rf.idx     = is_trans ? {~user, addr[15:13]} : {kset_hit, addr[3:1]};
   assign rf.sel_par = addr[5];
   assign rf.we_lo   = do_wr & set_hit & ~addr[0];      // odd address is high byte only
   assign rf.we_hi   = do_wr & set_hit;
   assign rf.wdata   = wdata;
   assign rf.set_w   = in_check & mapped & ~fault & (cmd == CMD_TRANS_WR);

   assign sr.wr_sr0    = do_wr & sr0_hit;
   assign sr.wr_sr3    = do_wr & sr3_hit;
   assign sr.wdata     = wdata;
   assign sr.rec_abort = in_check & mapped & fault;
   assign sr.rec_ok    = in_check & mapped & ~fault;
   assign sr.page      = addr[15:13];
   assign sr.user      = user;
   assign sr.flags     = {reloc_res.nr, reloc_res.le, reloc_res.ro};

   assign reloc_start = (state == ST_LOOKUP) & mapped;
   assign reloc_va    = addr;
   assign reloc_par   = rf.par;
   assign reloc_pdr   = rf.pdr;
   assign reloc_wr    = (cmd == CMD_TRANS_WR);
   assign reloc_as    = sr.as_en;

   always_comb
   begin
      rd_mux = '0;                                    // unmapped reads as zero
      if (sr0_hit)
         rd_mux = sr.sr0;
      else if (sr3_hit)
         rd_mux = sr.sr3;
      else if (set_hit)
         rd_mux = addr[5] ? rf.par : rf.pdr;
   end

   always_ff @(posedge clk)
   begin
      if (sr_rst)
      begin
         rdata <= '0;
         pa    <= '0;
         abort <= 1'b0;
      end
      else if (in_check)
      begin
         rdata <= (cmd == CMD_REG_RD) ? rd_mux : '0;
         pa    <= mapped ? reloc_res.pa : paddr_t'(addr);
         abort <= mapped & fault;
      end
   end

   // req has to stay up through the whole lookup before ack may rise
   a_ack_needs_req: assert property (@(posedge clk) disable iff (sr_rst)
      $rose(ack) |-> $past(req, 1) && $past(req, 2) && $past(req, 3));

   a_state_legal: assert property (@(posedge clk) disable iff (sr_rst)
      state inside {ST_IDLE, ST_DECODE, ST_LOOKUP, ST_CHECK, ST_ACK});

endmodule

// File: verilog/mmu_regfile.sv
`timescale 1ns/1ps

module mmu_regfile import mmu_pkg::*;
(
   input  logic   clk,
   input  logic   sr_rst,
   mmu_rf_if.rf   rf
);

   word_t par_mem [RF_SIZE];
   word_t pdr_mem [RF_SIZE];              // unwritable bits stay zero

   always_ff @(posedge clk)
   begin
      if (sr_rst)
      begin
         for (int i = 0; i < RF_SIZE; i++)
         begin
            par_mem[i] <= '0;
            pdr_mem[i] <= '0;
         end
      end
      else if (rf.set_w)
         pdr_mem[rf.idx][PDR_W_BIT] <= 1'b1;          // page written
      else if (rf.sel_par)
      begin
         if (rf.we_lo)
            par_mem[rf.idx][7:0] <= rf.wdata[7:0];
         if (rf.we_hi)
            par_mem[rf.idx][15:8] <= rf.wdata[15:8];
      end
      else if (rf.we_lo || rf.we_hi)
      begin
         pdr_mem[rf.idx][PDR_W_BIT] <= 1'b0;          // new descriptor is clean
         if (rf.we_lo)
            pdr_mem[rf.idx][PDR_ED_BIT:PDR_ACC_LSB] <= rf.wdata[PDR_ED_BIT:PDR_ACC_LSB];
         if (rf.we_hi)
            pdr_mem[rf.idx][PDR_PLF_MSB:PDR_PLF_LSB] <= rf.wdata[PDR_PLF_MSB:PDR_PLF_LSB];
      end
   end

   assign rf.par = par_mem[rf.idx];
   assign rf.pdr = pdr_mem[rf.idx] & PDR_RD_MASK;

   // dirty update and software access come from different FSM states
   a_w_vs_write: assert property (@(posedge clk) disable iff (sr_rst)
      !(rf.set_w && (rf.we_lo || rf.we_hi)));

endmodule

// File: verilog/mmu_reloc.sv
`timescale 1ns/1ps

module mmu_reloc import mmu_pkg::*;
(
   input  logic       clk,
   input  logic       sr_rst,
   input  logic       start,
   input  word_t      va,
   input  word_t      par,
   input  word_t      pdr,
   input  logic       is_wr,
   input  logic       as_en,
   output reloc_res_t res
);

   paddr_t     sum;
   logic [1:0] acc;
   logic [6:0] blk, plf;
   logic       len_err;

   // PAR counts 64-byte blocks, the offset is the low 13 VA bits
   assign sum = {par, 6'o00} + paddr_t'(va[12:0]);

   assign acc = pdr[PDR_ACC_MSB:PDR_ACC_LSB];
   assign blk = va[12:6];
   assign plf = pdr[PDR_PLF_MSB:PDR_PLF_LSB];

   // upward pages grow from 0, downward pages end at the top
   assign len_err = pdr[PDR_ED_BIT] ? (blk < plf) : (blk > plf);

   always_ff @(posedge clk)
   begin
      if (sr_rst)
         res <= '0;
      else if (start)
      begin
         res.pa <= as_en ? sum : {4'h0, sum[17:0]};   // 18-bit unless SR3 AS
         res.nr <= ~acc[0];
         res.le <= len_err;
         res.ro <= is_wr & (acc == 2'b01);
      end
   end

endmodule

// File: verilog/mmu_status.sv
`timescale 1ns/1ps

module mmu_status import mmu_pkg::*;
(
   input  logic   clk,
   input  logic   sr_rst,
   mmu_sr_if.sr   sr
);

   logic [2:0] abt_flags;                 // SR0 15..13 {nr, le, ro}
   logic [2:0] abt_page;                  // SR0 3..1
   logic       abt_mode;                  // SR0 6..5
   logic       en_bit;                    // SR0 0
   logic       as_bit;                    // SR3 4

   assign sr.frozen = |abt_flags;

   always_ff @(posedge clk)
   begin
      if (sr_rst)
      begin
         abt_flags <= 3'b000;
         abt_page  <= 3'b000;
         abt_mode  <= 1'b0;
         en_bit    <= 1'b0;
         as_bit    <= 1'b0;
      end
      else
      begin
         if (sr.wr_sr0)
         begin
            abt_flags <= sr.wdata[15:13];          // writing zero unfreezes
            en_bit    <= sr.wdata[0];
         end
         else if (!sr.frozen && (sr.rec_ok || sr.rec_abort))
         begin
            abt_page <= sr.page;
            abt_mode <= sr.user;
            if (sr.rec_abort)
               abt_flags <= sr.flags;
         end
         if (sr.wr_sr3)
            as_bit <= sr.wdata[SR3_AS_BIT];
      end
   end

   assign sr.sr0    = {abt_flags, 6'o00, abt_mode, abt_mode, 1'b0, abt_page, en_bit};
   assign sr.sr3    = word_t'(as_bit) << SR3_AS_BIT;
   assign sr.mmu_en = en_bit;
   assign sr.as_en  = as_bit;

endmodule

// File: verilog/dc304_mmu.sv
`timescale 1ns/1ps

module dc304_mmu import mmu_pkg::*;
(
   input  logic     clk,
   input  logic     sr_rst,
   input  logic     req,
   input  mmu_cmd_e cmd,
   input  logic     user,                 // 1 for user mode
   input  word_t    addr,
   input  word_t    wdata,
   output logic     ack,
   output word_t    rdata,
   output paddr_t   pa,
   output logic     abort
);

   mmu_rf_if   rf_bus ();
   mmu_sr_if   sr_bus ();

   logic       reloc_start;
   word_t      reloc_va;
   word_t      reloc_par;
   word_t      reloc_pdr;
   logic       reloc_wr;
   logic       reloc_as;
   reloc_res_t reloc_res;

   mmu_ctrl u_ctrl
   (
      .clk         (clk),
      .sr_rst      (sr_rst),
      .req         (req),
      .ack         (ack),
      .cmd         (cmd),
      .user        (user),
      .addr        (addr),
      .wdata       (wdata),
      .rdata       (rdata),
      .pa          (pa),
      .abort       (abort),
      .rf          (rf_bus),
      .sr          (sr_bus),
      .reloc_start (reloc_start),
      .reloc_va    (reloc_va),
      .reloc_par   (reloc_par),
      .reloc_pdr   (reloc_pdr),
      .reloc_wr    (reloc_wr),
      .reloc_as    (reloc_as),
      .reloc_res   (reloc_res)
   );

   mmu_regfile u_regfile
   (
      .clk    (clk),
      .sr_rst (sr_rst),
      .rf     (rf_bus)
   );

   mmu_reloc u_reloc
   (
      .clk    (clk),
      .sr_rst (sr_rst),
      .start  (reloc_start),
      .va     (reloc_va),
      .par    (reloc_par),
      .pdr    (reloc_pdr),
      .is_wr  (reloc_wr),
      .as_en  (reloc_as),
      .res    (reloc_res)
   );

   mmu_status u_status
   (
      .clk    (clk),
      .sr_rst (sr_rst),
      .sr     (sr_bus)
   );

endmodule

// File: testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen
(
   output logic clk,
   output logic sr_rst
);

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;              // 4 ns period
   end

   initial
   begin
      sr_rst <= 1'b1;
      repeat (4) @(posedge clk);
      sr_rst <= 1'b0;                     // four cycles of reset
   end

endmodule

// File: testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker import mmu_pkg::*;
(
   input  logic     clk,
   input  logic     sr_rst,
   input  logic     req,
   input  logic     ack,
   input  mmu_cmd_e cmd,
   input  word_t    rdata,
   input  paddr_t   pa,
   input  logic     abort,
   input  word_t    exp_rdata,
   input  paddr_t   exp_pa,
   input  logic     exp_abort,
   output int       mismatch_cnt,
   output int       timing_cnt,
   output int       ack_cnt
);

   logic prev_ack;
   logic prev_req;
   int   wait_cnt;                        // negedges with req up and ack still low

   task automatic compare_hex(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
      if (got !== exp)
      begin
         $display("[FAIL] %s expected %h got %h at %0t", name, exp, got, $time);
         mismatch_cnt++;
      end
   endtask

   // sampled on the falling edge, away from the edge where the DUT updates
   always @(negedge clk)
   begin
      if (sr_rst)
      begin
         prev_ack     = 1'b0;
         prev_req     = 1'b0;
         wait_cnt     = 0;
         mismatch_cnt = 0;
         timing_cnt   = 0;
         ack_cnt      = 0;
      end
      else
      begin
         if (ack && !prev_ack)
         begin
            ack_cnt++;
            // req rises between edges, so the first count comes before the sampling edge
            if (wait_cnt != 4)
            begin
               $display("ERROR: ack rose %0d cycles after req was sampled instead of 3",
                        wait_cnt - 1);
               timing_cnt++;
            end
            if (cmd == CMD_REG_RD)
               compare_hex("rdata", 32'(exp_rdata), 32'(rdata));
            else if (cmd != CMD_REG_WR)
            begin
               compare_hex("pa", 32'(exp_pa), 32'(pa));
               compare_hex("abort", 32'(exp_abort), 32'(abort));
            end
         end
         if (prev_ack && !ack && prev_req)
         begin
            $display("ERROR: ack fell while req was still held high");
            timing_cnt++;
         end
         if (req && !ack)
            wait_cnt++;
         else if (!req && !ack)
            wait_cnt = 0;                 // idle between handshakes
         prev_ack = ack;
         prev_req = req;
      end
   end

endmodule

// File: testbench/tb_dc304.sv
`timescale 1ns/1ps

module tb_dc304 import mmu_pkg::*; ();

   localparam int MAX_TRANS   = 64;
   localparam int FIELDS      = 7;        // words per golden line
   localparam int ACK_TIMEOUT = 32;       // cycles
   localparam int RST_TIMEOUT = 16;

   logic        clk;
   logic        sr_rst;
   logic        req;
   mmu_cmd_e    cmd;
   logic        user;
   word_t       addr;
   word_t       wdata;
   logic        ack;
   word_t       rdata;
   paddr_t      pa;
   logic        abort;

   word_t       exp_rdata;
   paddr_t      exp_pa;
   logic        exp_abort;
   int          mismatch_cnt;
   int          timing_cnt;
   int          ack_cnt;

   logic [31:0] gold [MAX_TRANS*FIELDS];
   integer      seed;
   int          tb_errors;
   int          n_acked;
   logic        stop;

   tb_clkgen u_clkgen
   (
      .clk    (clk),
      .sr_rst (sr_rst)
   );

   dc304_mmu dut0
   (
      .clk    (clk),
      .sr_rst (sr_rst),
      .req    (req),
      .cmd    (cmd),
      .user   (user),
      .addr   (addr),
      .wdata  (wdata),
      .ack    (ack),
      .rdata  (rdata),
      .pa     (pa),
      .abort  (abort)
   );

   tb_checker u_checker
   (
      .clk          (clk),
      .sr_rst       (sr_rst),
      .req          (req),
      .ack          (ack),
      .cmd          (cmd),
      .rdata        (rdata),
      .pa           (pa),
      .abort        (abort),
      .exp_rdata    (exp_rdata),
      .exp_pa       (exp_pa),
      .exp_abort    (exp_abort),
      .mismatch_cnt (mismatch_cnt),
      .timing_cnt   (timing_cnt),
      .ack_cnt      (ack_cnt)
   );

   task automatic wait_reset();
      int cycles;
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (sr_rst && cycles < RST_TIMEOUT);
      if (sr_rst)
      begin
         $display("ERROR: reset was not released within %0d cycles", RST_TIMEOUT);
         tb_errors++;
         stop = 1'b1;
      end
   endtask

   task automatic wait_ack(input logic level, input int trans);
      int cycles;
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (ack !== level && cycles < ACK_TIMEOUT);
      if (ack !== level)
      begin
         $display("ERROR: ack did not go to %b within %0d cycles in transaction %0d",
                  level, ACK_TIMEOUT, trans);
         tb_errors++;
         stop = 1'b1;
      end
   endtask

   task automatic run_trans(input int n);
      int base;
      int hold;
      base = n * FIELDS;
      @(posedge clk);
      cmd       <= mmu_cmd_e'(gold[base][1:0]);
      user      <= gold[base+1][0];
      addr      <= gold[base+2][15:0];
      wdata     <= gold[base+3][15:0];
      exp_rdata <= gold[base+4][15:0];
      exp_pa    <= gold[base+5][21:0];
      exp_abort <= gold[base+6][0];
      req       <= 1'b1;
      wait_ack(1'b1, n);
      if (!stop)
      begin
         n_acked++;
         hold = $unsigned($random(seed)) % 3;     // keep req up a little longer
         repeat (hold) @(posedge clk);
         @(posedge clk);
         req <= 1'b0;
         wait_ack(1'b0, n);
      end
   endtask

   initial
   begin
      int n;
      req       <= 1'b0;
      cmd       <= CMD_REG_RD;
      user      <= 1'b0;
      addr      <= '0;
      wdata     <= '0;
      exp_rdata <= '0;
      exp_pa    <= '0;
      exp_abort <= 1'b0;
      seed      = 32'h3ead_6d6f;
      tb_errors = 0;
      n_acked   = 0;
      stop      = 1'b0;
      n         = 0;
      for (int i = 0; i < MAX_TRANS*FIELDS; i++)
         gold[i] = '1;                    // all ones marks the end of the data
      $readmemh("testbench/dc304_golden.txt", gold);
      wait_reset();
      while (!stop && n < MAX_TRANS && gold[n*FIELDS] != '1)
      begin
         run_trans(n);
         n++;
      end
      if (n == 0)
      begin
         $display("ERROR: no transactions were found in the golden file");
         tb_errors++;
      end
      repeat (2) @(posedge clk);
      if (ack_cnt != n_acked)
      begin
         $display("ERROR: checker saw %0d acks but %0d handshakes completed",
                  ack_cnt, n_acked);
         tb_errors++;
      end
      $display("errors: data %0d, timing %0d, testbench %0d over %0d transactions",
               mismatch_cnt, timing_cnt, tb_errors, n);
      if (mismatch_cnt + timing_cnt + tb_errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: flist.f
verilog/mmu_pkg.sv
verilog/mmu_if.sv
verilog/mmu_ctrl.sv
verilog/mmu_regfile.sv
verilog/mmu_reloc.sv
verilog/mmu_status.sv
verilog/dc304_mmu.sv
testbench/tb_clkgen.sv
testbench/tb_checker.sv
testbench/tb_dc304.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the MMU testbench, the verdict comes from the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dc304 \
   -f flist.f -Mdir obj_dir -o tb_dc304 > build.log 2>&1 \
   && ./obj_dir/tb_dc304 | tee sim.log \
   || { echo "build or simulation failed, see build.log"; exit 1; }

grep -q "CHECKS FAILED" sim.log && { echo "FAIL"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "no verdict found in sim.log"; exit 1; }
echo "PASS"

// File: testbench/dc304_golden.txt
// cmd user addr wdata exp_rdata exp_pa exp_abort, all hex, one transaction per line
// cmd 0 read translation, 1 write translation, 2 register read, 3 register write
0 0 1234 0000 0000 001234 0
1 1 abcd 0000 0000 00abcd 0
2 0 ff7a 0000 0000 000000 0
3 0 f4e0 0100 0000 000000 0
3 0 f4c0 7f06 0000 000000 0
3 0 f4e2 f00f 0000 000000 0
3 0 f4c2 7f06 0000 000000 0
3 0 f4e4 0200 0000 000000 0
3 0 f4c4 7f00 0000 000000 0
3 0 f4e6 0300 0000 000000 0
3 0 f4c6 7f02 0000 000000 0
3 0 f4e8 0400 0000 000000 0
3 0 f4c8 1006 0000 000000 0
3 0 f4ea 0500 0000 000000 0
3 0 f4ca 700e 0000 000000 0
3 0 ffa0 0abc 0000 000000 0
3 0 ff80 7f06 0000 000000 0
3 0 ff8e ffff 0000 000000 0
2 0 f4e2 0000 f00f 000000 0
2 0 f4ca 0000 700e 000000 0
2 0 ffa0 0000 0abc 000000 0
2 0 ff8e 0000 7f0e 000000 0
2 0 f4c6 0000 7f02 000000 0
2 0 f4d0 0000 0000 000000 0
3 0 ff7a 0001 0000 000000 0
2 0 ff7a 0000 0001 000000 0
0 0 0123 0000 0000 004123 0
0 0 3abc 0000 0000 001e7c 0
2 0 ff7a 0000 0003 000000 0
2 0 f4c2 0000 7f06 000000 0
1 0 0010 0000 0000 004010 0
2 0 f4c0 0000 7f46 000000 0
0 1 0042 0000 0000 02af42 0
2 0 ff7a 0000 0061 000000 0
3 0 f54e ffff 0000 000000 0
2 0 f54e 0000 0010 000000 0
0 0 3abc 0000 0000 3c1e7c 0
0 0 4000 0000 0000 008000 1
2 0 ff7a 0000 8005 000000 0
3 0 ff7a 0001 0000 000000 0
1 0 6008 0000 0000 00c008 1
2 0 ff7a 0000 2007 000000 0
2 0 f4c6 0000 7f02 000000 0
0 0 0123 0000 0000 004123 0
2 0 ff7a 0000 2007 000000 0
3 0 ff7a 0001 0000 000000 0
2 0 ff7a 0000 0007 000000 0
0 0 8400 0000 0000 010400 0
0 0 8440 0000 0000 010440 1
2 0 ff7a 0000 4009 000000 0
3 0 ff7a 0001 0000 000000 0
0 0 bc00 0000 0000 015c00 0
0 0 bbc0 0000 0000 015bc0 1
2 0 ff7a 0000 400b 000000 0
3 0 f4c0 7f06 0000 000000 0
2 0 f4c0 0000 7f06 000000 0
